//--- Makefile
# Verilator build and run of the FFT testbench.

TOP       ?= fft8_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator
SIM_FLAGS ?= --binary --timing --assert --timescale 1ns/100ps
PASS_TEXT := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: TOP, FILELIST, BUILD_DIR, VERILATOR, SIM_FLAGS"

test:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- common/fft_config.svh
`ifndef FFT_CONFIG_SVH
`define FFT_CONFIG_SVH

// Fixed-point format of one real or imaginary part.
// Values are two's complement with FFT_FRACTION bits below the binary point,
// so 1.0 is 256 and the range is about -128.0 to +127.996.
`define FFT_WORD_SIZE 16
`define FFT_FRACTION 8

// Transform size.
// The twiddle table and the shuffle in the core are written for 8 points.
`define FFT_POINTS 8

// One radix-2 pass per factor of two in the frame length.
`define FFT_PASSES 3

`endif

//--- common/fft_ctrl_pkg.sv
`include "fft_config.svh"

package fft_ctrl_pkg;

	// Index of the pass being computed, 0 to FFT_PASSES-1.
	typedef logic [$clog2(`FFT_PASSES)-1:0] pass_t;

	// What the frame register takes on the next edge.
	typedef enum logic [1:0] {
		SEL_HOLD,
		SEL_INPUT,
		SEL_FEEDBACK
	} load_sel_t;

endpackage

//--- common/fft_types_pkg.sv
`include "fft_config.svh"

package fft_types_pkg;

	// One signed part in Q(WORD_SIZE-FRACTION).FRACTION.
	typedef logic signed [`FFT_WORD_SIZE-1:0] sample_t;

	// Complex sample, real part in the upper half.
	typedef struct packed {
		sample_t re;
		sample_t im;
	} complex_t;

	// A whole frame, element 0 in the lowest bits.
	// At the input this is time order.
	// After the last pass position i holds bin bitrev(i), scaled by 1/N.
	typedef complex_t [`FFT_POINTS-1:0] frame_t;

endpackage

//--- fft_core/butterfly_stage.sv
`timescale 1ns/100ps

`include "fft_config.svh"

module butterfly_stage
	import fft_types_pkg::*;
	import fft_ctrl_pkg::*;
(
	input  frame_t i_frame,
	input  pass_t  i_pass,
	output frame_t o_results
);

	localparam int W = `FFT_WORD_SIZE;
	localparam int F = `FFT_FRACTION;
	localparam int HALF = `FFT_POINTS / 2;
	localparam int EXP_BITS = $clog2(HALF);

	// Twiddle magnitudes in the working format.
	localparam int ONE = 1 << F;
	localparam int COS45 = int'(0.7071067811865476 * ONE);

	// W8^e = cos(2*pi*e/8) - j*sin(2*pi*e/8).
	function automatic complex_t twiddle(input logic [EXP_BITS-1:0] e);
		complex_t w;
		case (e)
			2'd0: begin
				w.re = sample_t'(ONE);
				w.im = '0;
			end
			2'd1: begin
				w.re = sample_t'(COS45);
				w.im = sample_t'(-COS45);
			end
			2'd2: begin
				w.re = '0;
				w.im = sample_t'(-ONE);
			end
			default: begin
				w.re = sample_t'(-COS45);
				w.im = sample_t'(-COS45);
			end
		endcase
		return w;
	endfunction

	// Exponent mask, the low i_pass bits of k are cleared.
	logic [EXP_BITS-1:0] pass_mask;

	assign pass_mask = {EXP_BITS{1'b1}} << i_pass;

	for (genvar k = 0; k < HALF; k++) begin : g_bfly
		complex_t             a;
		complex_t             b;
		complex_t             w;
		complex_t             d;
		logic [EXP_BITS-1:0]  e;
		logic signed [W:0]    sum_re;
		logic signed [W:0]    sum_im;
		logic signed [W:0]    dif_re;
		logic signed [W:0]    dif_im;
		logic signed [2*W:0]  prod_re;
		logic signed [2*W:0]  prod_im;

		assign a = i_frame[k];
		assign b = i_frame[k+HALF];

		assign e = EXP_BITS'(k) & pass_mask;
		assign w = twiddle(e);

		// One guard bit, then halve by dropping the lowest bit.
		assign sum_re = {a.re[W-1], a.re} + {b.re[W-1], b.re};
		assign sum_im = {a.im[W-1], a.im} + {b.im[W-1], b.im};
		assign dif_re = {a.re[W-1], a.re} - {b.re[W-1], b.re};
		assign dif_im = {a.im[W-1], a.im} - {b.im[W-1], b.im};

		assign d.re = dif_re[W:1];
		assign d.im = dif_im[W:1];

		// Full precision complex multiply.
		assign prod_re = $signed(d.re) * $signed(w.re) - $signed(d.im) * $signed(w.im);
		assign prod_im = $signed(d.re) * $signed(w.im) + $signed(d.im) * $signed(w.re);

		// Sum and diff leave as an adjacent pair.
		assign o_results[2*k].re = sum_re[W:1];
		assign o_results[2*k].im = sum_im[W:1];

		// Truncate back to Q8
		assign o_results[2*k+1].re = prod_re[W+F-1:F];
		assign o_results[2*k+1].im = prod_im[W+F-1:F];
	end

endmodule

//--- fft_core/frame_buffer.sv
`timescale 1ns/100ps

`include "fft_config.svh"

module frame_buffer
	import fft_types_pkg::*;
	import fft_ctrl_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  load_sel_t i_sel,
	input  frame_t    i_frame,
	input  frame_t    i_results,
	output frame_t    o_frame
);

	localparam int HALF = `FFT_POINTS / 2;

	frame_t frame;

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			frame <= '0;
		end else begin
			case (i_sel)
				SEL_INPUT: begin
					frame <= i_frame;
				end
				SEL_FEEDBACK: begin
					// Perfect shuffle.
					// Butterfly k read positions k and k+4 and lands in 2k and 2k+1,
					// which keeps the read pairing the same on every pass.
					for (int k = 0; k < HALF; k++) begin
						frame[2*k]   <= i_results[2*k];
						frame[2*k+1] <= i_results[2*k+1];
					end
				end
				default: begin
					frame <= frame;
				end
			endcase
		end
	end

	assign o_frame = frame;

endmodule

//--- list.f
+incdir+common
common/fft_types_pkg.sv
common/fft_ctrl_pkg.sv
fft_core/butterfly_stage.sv
fft_core/frame_buffer.sv
source/pass_sequencer.sv
source/fft8_top.sv
testbench/fft8_properties.sv
testbench/fft8_tb.sv

//--- source/fft8_top.sv
`timescale 1ns/100ps

module fft8_top
	import fft_types_pkg::*;
	import fft_ctrl_pkg::*;
(
	input  logic   i_clk,
	input  logic   i_rst,
	input  logic   i_start,
	input  frame_t i_frame,
	output logic   o_busy,
	output logic   o_done,
	output frame_t o_result
);

	load_sel_t sel;
	pass_t     pass;
	frame_t    work_frame;
	frame_t    bfly_results;

	// Start, busy and done control plus the pass count.
	pass_sequencer u_pass_sequencer (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (i_start),
		.o_sel   (sel),
		.o_pass  (pass),
		.o_busy  (o_busy),
		.o_done  (o_done)
	);

	// Working frame, loaded from outside or fed back after each pass.
	frame_buffer u_frame_buffer (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_sel     (sel),
		.i_frame   (i_frame),
		.i_results (bfly_results),
		.o_frame   (work_frame)
	);

	// One pass worth of butterflies, purely combinational.
	butterfly_stage u_butterfly_stage (
		.i_frame   (work_frame),
		.i_pass    (pass),
		.o_results (bfly_results)
	);

	// The register holds the finished frame until the next start.
	assign o_result = work_frame;

endmodule

//--- source/pass_sequencer.sv
`timescale 1ns/100ps

`include "fft_config.svh"

module pass_sequencer
	import fft_ctrl_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_start,
	output load_sel_t o_sel,
	output pass_t     o_pass,
	output logic      o_busy,
	output logic      o_done
);

	localparam pass_t LAST_PASS = pass_t'(`FFT_PASSES - 1);

	logic  busy;
	logic  done;
	pass_t pass;
	logic  accept;
	logic  last_pass;

	// A start is only taken while idle.
	assign accept = i_start & ~busy;

	// The edge that ends this cycle writes the final pass.
	assign last_pass = busy && (pass == LAST_PASS);

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			busy <= 1'b0;
			pass <= '0;
			done <= 1'b0;
		end else begin
			// Single cycle pulse on the final pass edge.
			done <= last_pass;

			if (accept) begin
				busy <= 1'b1;
				pass <= '0;
			end else if (busy) begin
				if (last_pass) begin
					busy <= 1'b0;
					pass <= '0;
				end else begin
					pass <= pass + 1'b1;
				end
			end
		end
	end

	// Load select for the frame register.
	// It takes effect on the coming edge, so the input select follows
	// the start pulse directly.
	always_comb begin
		if (busy) begin
			o_sel = SEL_FEEDBACK;
		end else if (i_start) begin
			o_sel = SEL_INPUT;
		end else begin
			o_sel = SEL_HOLD;
		end
	end

	assign o_pass = pass;
	assign o_busy = busy;
	assign o_done = done;

endmodule

//--- testbench/fft8_properties.sv
`timescale 1ns/100ps

module fft8_properties (
	input logic i_clk,
	input logic i_rst,
	input logic i_start,
	input logic o_busy,
	input logic o_done
);

	// Done is a single cycle pulse.
	done_one_cycle: assert property (
		@(posedge i_clk) disable iff (i_rst)
		o_done |=> !o_done
	) else $error("o_done was high for more than one cycle");

	// Done rises on the third edge after the accepting edge,
	// which the sampled values show one clock later.
	done_after_start: assert property (
		@(posedge i_clk) disable iff (i_rst)
		(i_start && !o_busy) |-> ##4 o_done
	) else $error("o_done did not follow an accepted start after three cycles");

	// Status outputs stay low through reset.
	idle_in_reset: assert property (
		@(posedge i_clk)
		i_rst |-> (!o_busy && !o_done)
	) else $error("o_busy or o_done was high while i_rst was asserted");

endmodule

bind fft8_top fft8_properties u_properties (
	.i_clk   (i_clk),
	.i_rst   (i_rst),
	.i_start (i_start),
	.o_busy  (o_busy),
	.o_done  (o_done)
);

//--- testbench/fft8_tb.sv
`timescale 1ns/100ps

`include "fft_config.svh"

module fft8_tb
	import fft_types_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int DRIVE_DELAY = 1;
	localparam int HALF = `FFT_POINTS / 2;
	localparam int RANDOM_FRAMES = 20;

	// Impulse, constant, two in the busy test, two in the reset test.
	localparam int FRAME_COUNT = RANDOM_FRAMES + 6;
	localparam int EXPECTED_RESULTS = RANDOM_FRAMES + 4;
	localparam int CYCLE_LIMIT = 20 * FRAME_COUNT + RESET_CYCLES;

	localparam int ONE_Q8 = 1 << `FFT_FRACTION;
	localparam int COS45_Q8 = int'(0.7071067811865476 * ONE_Q8);

	logic   i_clk;
	logic   i_rst;
	logic   i_start;
	frame_t i_frame;
	logic   o_busy;
	logic   o_done;
	frame_t o_result;

	frame_t expected_q[$];
	int     errors = 0;
	int     checks = 0;
	int     done_count = 0;
	int     cycles = 0;

	fft8_top i_dut (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (i_start),
		.i_frame  (i_frame),
		.o_busy   (o_busy),
		.o_done   (o_done),
		.o_result (o_result)
	);

	initial begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	// W8^e = cos(2*pi*e/8) - j*sin(2*pi*e/8) in Q8.
	function automatic void twiddle_q8(input int e, output int w_re, output int w_im);
		case (e)
			0: begin
				w_re = ONE_Q8;
				w_im = 0;
			end
			1: begin
				w_re = COS45_Q8;
				w_im = -COS45_Q8;
			end
			2: begin
				w_re = 0;
				w_im = -ONE_Q8;
			end
			default: begin
				w_re = -COS45_Q8;
				w_im = -COS45_Q8;
			end
		endcase
	endfunction

	// Constant-geometry DIF passes, halved sums and truncated twiddle products.
	function automatic frame_t fft8_model(input frame_t x);
		frame_t cur;
		frame_t nxt;
		int     a_re;
		int     a_im;
		int     b_re;
		int     b_im;
		int     d_re;
		int     d_im;
		int     w_re;
		int     w_im;
		int     e;
		cur = x;
		for (int p = 0; p < `FFT_PASSES; p++) begin
			for (int k = 0; k < HALF; k++) begin
				a_re = int'(cur[k].re);
				a_im = int'(cur[k].im);
				b_re = int'(cur[k+HALF].re);
				b_im = int'(cur[k+HALF].im);
				e = k & ~((1 << p) - 1);
				twiddle_q8(e, w_re, w_im);
				nxt[2*k].re = sample_t'((a_re + b_re) >>> 1);
				nxt[2*k].im = sample_t'((a_im + b_im) >>> 1);
				d_re = (a_re - b_re) >>> 1;
				d_im = (a_im - b_im) >>> 1;
				nxt[2*k+1].re = sample_t'((d_re * w_re - d_im * w_im) >>> `FFT_FRACTION);
				nxt[2*k+1].im = sample_t'((d_re * w_im + d_im * w_re) >>> `FFT_FRACTION);
			end
			cur = nxt;
		end
		return cur;
	endfunction

	function automatic frame_t random_frame();
		frame_t f;
		for (int i = 0; i < `FFT_POINTS; i++) begin
			f[i].re = sample_t'(int'($urandom_range(254)) - 127);
			f[i].im = sample_t'(int'($urandom_range(254)) - 127);
		end
		return f;
	endfunction

	// Compare process, one expected frame per done pulse.
	always @(negedge i_clk) begin
		frame_t exp_frame;
		if (o_done) begin
			done_count++;
			assert (!o_busy) else begin
				$display("Error at %0t: o_busy was still high when o_done rose", $time);
				errors++;
			end
			assert (expected_q.size() != 0) else begin
				$display("Error at %0t: o_done pulsed with no frame outstanding", $time);
				errors++;
			end
			if (expected_q.size() != 0) begin
				exp_frame = expected_q.pop_front();
				for (int i = 0; i < `FFT_POINTS; i++) begin
					checks++;
					assert (o_result[i] == exp_frame[i]) else begin
						$display("Fail %0t: word %0d is re %0d im %0d, expected re %0d im %0d",
							$time, i, o_result[i].re, o_result[i].im,
							exp_frame[i].re, exp_frame[i].im);
						errors++;
					end
				end
			end
		end
	end

	always @(posedge i_clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	task automatic drive_start(input frame_t f);
		@(posedge i_clk);
		#DRIVE_DELAY;
		i_frame = f;
		i_start = 1'b1;
		@(posedge i_clk);
		#DRIVE_DELAY;
		i_start = 1'b0;
	endtask

	task automatic send_frame(input frame_t f, input frame_t exp_frame);
		expected_q.push_back(exp_frame);
		drive_start(f);
	endtask

	task automatic wait_results();
		while (expected_q.size() != 0) begin
			@(posedge i_clk);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("%s: finished with %0d errors", name, errors - errors_before);
	endtask

	task automatic test_impulse();
		frame_t f;
		frame_t exp_frame;
		int     errors_before;
		errors_before = errors;
		f = '0;
		f[0].re = sample_t'(ONE_Q8);
		for (int i = 0; i < `FFT_POINTS; i++) begin
			exp_frame[i].re = sample_t'(ONE_Q8 / 8);
			exp_frame[i].im = '0;
		end
		send_frame(f, exp_frame);
		wait_results();
		report_test("impulse", errors_before);
	endtask

	task automatic test_constant();
		frame_t f;
		frame_t exp_frame;
		int     errors_before;
		errors_before = errors;
		for (int i = 0; i < `FFT_POINTS; i++) begin
			f[i].re = sample_t'(ONE_Q8);
			f[i].im = '0;
		end
		exp_frame = '0;
		exp_frame[0].re = sample_t'(ONE_Q8);
		send_frame(f, exp_frame);
		wait_results();
		report_test("constant", errors_before);
	endtask

	task automatic test_random();
		frame_t f;
		int     errors_before;
		errors_before = errors;
		for (int n = 0; n < RANDOM_FRAMES; n++) begin
			f = random_frame();
			send_frame(f, fft8_model(f));
			wait_results();
		end
		report_test("random frames", errors_before);
	endtask

	task automatic test_start_while_busy();
		frame_t first;
		frame_t second;
		int     errors_before;
		int     dones_before;
		errors_before = errors;
		dones_before = done_count;
		first = random_frame();
		second = random_frame();
		send_frame(first, fft8_model(first));
		assert (o_busy) else begin
			$display("Error at %0t: o_busy was low right after the start was accepted",
				$time);
			errors++;
		end
		// Second start one cycle later, while busy.
		i_frame = second;
		i_start = 1'b1;
		@(posedge i_clk);
		#DRIVE_DELAY;
		i_start = 1'b0;
		wait_results();
		repeat (5) @(posedge i_clk);
		assert (done_count == dones_before + 1) else begin
			$display("Error at %0t: a start while busy changed the number of done pulses",
				$time);
			errors++;
		end
		report_test("start while busy", errors_before);
	endtask

	task automatic test_reset_mid_run();
		frame_t f;
		int     errors_before;
		int     dones_before;
		errors_before = errors;
		dones_before = done_count;
		f = random_frame();
		drive_start(f);
		@(posedge i_clk);
		#DRIVE_DELAY;
		i_rst = 1'b1;
		#DRIVE_DELAY;
		assert (!o_busy && !o_done && o_result == '0) else begin
			$display("Fail %0t: busy %0b done %0b after reset, expected both low and a zero frame",
				$time, o_busy, o_done);
			errors++;
		end
		repeat (2) @(posedge i_clk);
		#DRIVE_DELAY;
		i_rst = 1'b0;
		repeat (6) @(posedge i_clk);
		assert (done_count == dones_before) else begin
			$display("Error at %0t: the aborted frame still produced a done pulse", $time);
			errors++;
		end
		f = random_frame();
		send_frame(f, fft8_model(f));
		wait_results();
		report_test("reset mid-run", errors_before);
	endtask

	initial begin
		i_rst = 1'b1;
		i_start = 1'b0;
		i_frame = '0;
		void'($urandom(32'h52eb));
		repeat (RESET_CYCLES) @(posedge i_clk);
		#DRIVE_DELAY;
		i_rst = 1'b0;

		test_impulse();
		test_constant();
		test_random();
		test_start_while_busy();
		test_reset_mid_run();

		assert (done_count == EXPECTED_RESULTS) else begin
			$display("Error: saw %0d results where %0d were expected",
				done_count, EXPECTED_RESULTS);
			errors++;
		end
		$display("Results: %0d, word checks: %0d, errors: %0d", done_count, checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
